// File: Makefile
# Verilator build and run of the video register port testbench

VERILATOR ?= verilator
TOP       ?= tb_video_regs
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sources.f
verilog/host_bus_pkg.sv
verilog/vram_pkg.sv
verilog/vram.sv
verilog/bus_interface.sv
verilog/vram_regs.sv
verilog/video_regs_top.sv
verif/tb_video_regs.sv

// File: verif/tb_video_regs.sv
// ##########################################################################
// testbench for the video controller register port
//   clock, reset and host bus byte and word cycles
//   reference model of address registers, prefetch word and VRAM
//   six directed tests with per test report and cycle timeout
// ##########################################################################

`timescale 1ns/1ps

module tb_video_regs;

    localparam int          ADDR_W    = vram_pkg::VRAM_ADDR_W_DEF;
    localparam logic [15:0] ADDR_MASK = 16'((1 << ADDR_W) - 1);
    localparam int          TIMEOUT   = 6 * 40 * 20 + 100;  // tests x words x cycles per word

    logic       clk;
    logic       reset_i;
    logic       bus_cs_n_i;
    logic       bus_rd_nwr_i;
    logic [3:0] bus_reg_num_i;
    logic       bus_bytesel_i;
    logic [7:0] bus_data_i;
    logic [7:0] bus_data_o;

    integer seed = 32'h5f074c14;
    int     errors;
    int     checks;
    int     test_errors;
    int     cycles;

    logic [15:0] m_addr [16];           // model vram, direct mapped on low nibble
    logic [15:0] m_val  [16];
    logic [15:0] m_rd;                  // model read address
    logic [15:0] m_wr;                  // model write address
    logic [15:0] m_incr;
    logic [15:0] m_prefetch;

    video_regs_top #(.VRAM_ADDR_W (ADDR_W)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, bus cycles stopped completing", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [15:0] model_read(input logic [15:0] addr);
        if (m_addr[addr[3:0]] == addr) begin
            return m_val[addr[3:0]];
        end
        return 16'hxxxx;                // never written, ram holds unknown data
    endfunction

    function automatic void model_write(input logic [15:0] addr, input logic [15:0] val);
        m_addr[addr[3:0]] = addr;
        m_val[addr[3:0]]  = val;
    endfunction

    // one select pulse, entered and left 1 ns after a rising edge
    task automatic byte_cycle(input logic rd, input logic [3:0] num, input logic sel,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        bus_rd_nwr_i  = rd ? host_bus_pkg::RNW_READ : !host_bus_pkg::RNW_READ;
        bus_reg_num_i = num;
        bus_bytesel_i = sel;
        bus_data_i    = wdata;
        bus_cs_n_i    = host_bus_pkg::CS_ENABLED;
        repeat (3) @(posedge clk);
        #1 rdata = bus_data_o;          // synced, prefetch not yet refreshed
        repeat (3) @(posedge clk);
        #1 bus_cs_n_i = !host_bus_pkg::CS_ENABLED;
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic bus_write_word(input logic [3:0] num, input logic [15:0] word);
        logic [7:0] unused;
        byte_cycle(1'b0, num, 1'b0, word[15:8], unused);   // even byte first
        byte_cycle(1'b0, num, 1'b1, word[7:0], unused);
    endtask

    task automatic bus_read_word(input logic [3:0] num, output logic [15:0] word);
        byte_cycle(1'b1, num, 1'b0, 8'h00, word[15:8]);
        byte_cycle(1'b1, num, 1'b1, 8'h00, word[7:0]);      // strobes the read
    endtask

    task automatic write_reg(input logic [3:0] num, input logic [15:0] val);
        bus_write_word(num, val);
        case (num)
            host_bus_pkg::REG_RD_ADDR: begin
                m_rd       = val & ADDR_MASK;
                m_prefetch = model_read(m_rd);
            end
            host_bus_pkg::REG_WR_ADDR: m_wr = val & ADDR_MASK;
            host_bus_pkg::REG_DATA: begin
                model_write(m_wr, val);
                m_wr = (m_wr + m_incr) & ADDR_MASK;
            end
            host_bus_pkg::REG_INCR: m_incr = val;
            default: ;                  // id registers ignore writes
        endcase
    endtask

    task automatic read_check(input logic [3:0] num);
        logic [15:0] exp;
        logic [15:0] got;
        case (num)
            host_bus_pkg::REG_RD_ADDR: exp = m_rd;
            host_bus_pkg::REG_WR_ADDR: exp = m_wr;
            host_bus_pkg::REG_DATA:    exp = m_prefetch;
            host_bus_pkg::REG_INCR:    exp = m_incr;
            default:                   exp = {8'hA0 + 8'(num[3:2]), 8'hB0 + 8'(num[3:2])};
        endcase
        bus_read_word(num, got);
        checks++;
        assert (got === exp) else begin
            $display("Fail %0t bus_data_o reg %0h expected %h got %h", $time, num, exp, got);
            errors++;
            test_errors++;
        end
        if (num == host_bus_pkg::REG_DATA) begin
            m_rd       = (m_rd + m_incr) & ADDR_MASK;   // data read steps and refetches
            m_prefetch = model_read(m_rd);
        end
    endtask

    task automatic test_done(input string name);
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        logic [15:0] word;
        logic [7:0]  rbyte;
        reset_i       = 1'b1;
        bus_cs_n_i    = !host_bus_pkg::CS_ENABLED;
        bus_rd_nwr_i  = host_bus_pkg::RNW_READ;
        bus_reg_num_i = 4'h0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = 8'h00;
        {m_rd, m_wr, m_incr, m_prefetch} = '0;
        for (int i = 0; i < 16; i++) begin
            m_addr[i] = 16'hffff;       // outside any address range
        end
        repeat (4) @(posedge clk);
        #1 reset_i = 1'b0;

        read_check(host_bus_pkg::REG_RD_ADDR);
        read_check(host_bus_pkg::REG_WR_ADDR);
        read_check(host_bus_pkg::REG_INCR);
        for (int n = 4; n < 16; n++) begin
            read_check(4'(n));
        end
        test_done("reset values and id bytes");

        write_reg(host_bus_pkg::REG_WR_ADDR, 16'($random(seed)));
        read_check(host_bus_pkg::REG_WR_ADDR);
        write_reg(host_bus_pkg::REG_RD_ADDR, 16'($random(seed)));
        read_check(host_bus_pkg::REG_RD_ADDR);
        write_reg(host_bus_pkg::REG_INCR, 16'($random(seed)));
        read_check(host_bus_pkg::REG_INCR);
        test_done("address and increment readback");

        write_reg(host_bus_pkg::REG_INCR, 16'h0001);
        write_reg(host_bus_pkg::REG_WR_ADDR, 16'h0040);
        for (int i = 0; i < 8; i++) begin
            write_reg(host_bus_pkg::REG_DATA, 16'($random(seed)));
        end
        read_check(host_bus_pkg::REG_WR_ADDR);
        write_reg(host_bus_pkg::REG_RD_ADDR, 16'h0040);
        for (int i = 0; i < 8; i++) begin
            read_check(host_bus_pkg::REG_DATA);
        end
        read_check(host_bus_pkg::REG_RD_ADDR);
        test_done("sequential write and readback");

        write_reg(host_bus_pkg::REG_INCR, 16'h0003);
        write_reg(host_bus_pkg::REG_WR_ADDR, 16'h0100);
        for (int i = 0; i < 6; i++) begin
            write_reg(host_bus_pkg::REG_DATA, 16'($random(seed)));
        end
        write_reg(host_bus_pkg::REG_RD_ADDR, 16'h0100);
        for (int i = 0; i < 6; i++) begin
            read_check(host_bus_pkg::REG_DATA);     // reads trail the second write run
            write_reg(host_bus_pkg::REG_DATA, 16'($random(seed)));
        end
        for (int i = 0; i < 6; i++) begin
            read_check(host_bus_pkg::REG_DATA);
        end
        read_check(host_bus_pkg::REG_RD_ADDR);
        read_check(host_bus_pkg::REG_WR_ADDR);
        test_done("stride 3 interleaved access");

        write_reg(host_bus_pkg::REG_INCR, 16'h0001);
        write_reg(host_bus_pkg::REG_WR_ADDR, 16'h0300);
        word = 16'($random(seed));
        byte_cycle(1'b0, host_bus_pkg::REG_INCR, 1'b0, word[15:8], rbyte);
        byte_cycle(1'b0, host_bus_pkg::REG_DATA, 1'b1, word[7:0], rbyte);
        model_write(m_wr, {8'h00, word[7:0]});      // odd byte alone, high byte zero
        m_wr = (m_wr + m_incr) & ADDR_MASK;
        read_check(host_bus_pkg::REG_INCR);
        read_check(host_bus_pkg::REG_WR_ADDR);
        write_reg(host_bus_pkg::REG_RD_ADDR, 16'h0300);
        read_check(host_bus_pkg::REG_DATA);
        test_done("split byte pair");

        write_reg(host_bus_pkg::REG_INCR, 16'h0005);
        write_reg(host_bus_pkg::REG_WR_ADDR, 16'h0200);
        write_reg(host_bus_pkg::REG_DATA, 16'($random(seed)));
        read_check(host_bus_pkg::REG_WR_ADDR);      // one step of 5 per word
        write_reg(host_bus_pkg::REG_RD_ADDR, 16'h0200);
        read_check(host_bus_pkg::REG_DATA);
        read_check(host_bus_pkg::REG_RD_ADDR);
        test_done("single access per bus cycle");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/bus_interface.sv
// ##########################################################################
// host bus interface
//   two stage synchronizers on the async 8-bit host bus
//   select edge detect and even/odd byte pairing into 16-bit words
//   single cycle register read and write strobes
//   read byte selection with id bytes for registers 4 to F
// ##########################################################################

`timescale 1ns/1ps

module bus_interface (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        bus_cs_n_i,     // chip select from host
    input  logic                        bus_rd_nwr_i,   // read when high
    input  logic [3:0]                  bus_reg_num_i,  // register number from host
    input  logic                        bus_bytesel_i,  // low selects even (high) byte
    input  logic [7:0]                  bus_data_i,     // host write data
    input  logic [vram_pkg::WORD_W-1:0] reg_data_i,     // word read from register block
    output logic [7:0]                  bus_data_o,     // host read data
    output logic                        write_strobe_o, // completed word write
    output logic                        read_strobe_o,  // odd byte read
    output host_bus_pkg::reg_num_e      reg_num_o,      // register being accessed
    output logic [vram_pkg::WORD_W-1:0] reg_data_o      // word to write to register
);

    // synchronizers shift right, new sample enters at the top bit
    logic [2:0]      sel_r;             // [2] first stage, [1] second stage, [0] edge stage
    logic [1:0]      read_r;
    logic [1:0]      bytesel_r;
    logic [1:0][3:0] reg_num_r;
    logic [1:0][7:0] data_r;

    // synchronized views of the bus
    logic            sel_rise;          // select just went active
    logic            write;
    logic            bytesel;
    logic [3:0]      reg_num;
    logic [7:0]      data;

    // buffered even byte waiting for its odd partner
    logic [3:0]      even_reg_r;        // register number the even byte was written to
    logic [7:0]      even_data_r;

    assign sel_rise = (sel_r[1:0] == 2'b10);        // active now, idle one cycle before
    assign write    = ~read_r[0];
    assign bytesel  = bytesel_r[0];
    assign reg_num  = reg_num_r[0];
    assign data     = data_r[0];

    assign reg_num_o = host_bus_pkg::reg_num_e'(reg_num);   // held while host holds address

    // read byte mux follows the synchronized address directly
    always_comb begin
        case (reg_num[3:2])
            2'b00:   bus_data_o = bytesel ? reg_data_i[7:0] : reg_data_i[15:8];  // real regs
            2'b01:   bus_data_o = bytesel ? 8'hB1 : 8'hA1;  // id bytes for 4 to 7
            2'b10:   bus_data_o = bytesel ? 8'hB2 : 8'hA2;  // id bytes for 8 to B
            default: bus_data_o = bytesel ? 8'hB3 : 8'hA3;  // id bytes for C to F
        endcase
    end

    // odd byte is paired with the even byte only if both hit the same register
    always_comb begin
        if (even_reg_r == reg_num) begin
            reg_data_o = {even_data_r, data};
        end else begin
            reg_data_o = {8'h00, data};     // lone odd byte, high byte cleared
        end
    end

    // data path synchronizers
    always_ff @(posedge clk) begin
        read_r    <= {(bus_rd_nwr_i == host_bus_pkg::RNW_READ), read_r[1]};
        bytesel_r <= {bus_bytesel_i, bytesel_r[1]};
        reg_num_r <= {bus_reg_num_i, reg_num_r[1]};
        data_r    <= {bus_data_i, data_r[1]};
        if (sel_rise && write && !bytesel) begin
            even_data_r <= data;            // hold even byte until odd byte arrives
        end
    end

    // select tracking, strobes and even byte tag
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sel_r          <= 3'b000;
            write_strobe_o <= 1'b0;
            read_strobe_o  <= 1'b0;
            even_reg_r     <= 4'h0;
        end else begin
            sel_r          <= {(bus_cs_n_i == host_bus_pkg::CS_ENABLED), sel_r[2:1]};
            write_strobe_o <= 1'b0;         // strobes last one cycle
            read_strobe_o  <= 1'b0;
            if (sel_rise) begin
                if (write) begin
                    if (bytesel) begin
                        write_strobe_o <= 1'b1;     // word complete on odd byte
                    end else begin
                        even_reg_r <= reg_num;      // tag the buffered even byte
                    end
                end else if (bytesel) begin
                    read_strobe_o <= 1'b1;  // one strobe per word read
                end
            end
        end
    end

endmodule

// File: verilog/host_bus_pkg.sv
// ##########################################################################
// host bus definitions shared by the register port and its testbench
//   chip select and read/write signal levels
//   register number enum for the four decoded registers
// ##########################################################################

package host_bus_pkg;

    // bus signal levels as seen on the pins
    localparam logic CS_ENABLED = 1'b0;     // select is active low
    localparam logic RNW_READ   = 1'b1;     // high on rd_nwr marks a read

    // register numbers decoded by the register block
    // numbers 4 to F are not decoded and read back id bytes
    typedef enum logic [3:0] {
        REG_RD_ADDR = 4'h0,                 // vram read address
        REG_WR_ADDR = 4'h1,                 // vram write address
        REG_DATA    = 4'h2,                 // vram data port
        REG_INCR    = 4'h3                  // address increment
    } reg_num_e;

endpackage

// File: verilog/video_regs_top.sv
// ##########################################################################
// video controller register port top level
//   host bus interface, VRAM access registers and video RAM
// ##########################################################################

`timescale 1ns/1ps

module video_regs_top #(
    parameter int VRAM_ADDR_W = vram_pkg::VRAM_ADDR_W_DEF
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       bus_cs_n_i,
    input  logic       bus_rd_nwr_i,
    input  logic [3:0] bus_reg_num_i,
    input  logic       bus_bytesel_i,
    input  logic [7:0] bus_data_i,
    output logic [7:0] bus_data_o
);

    // bus side to register block
    logic                        write_strobe;
    logic                        read_strobe;
    host_bus_pkg::reg_num_e      reg_num;
    logic [vram_pkg::WORD_W-1:0] bus_wr_word;      // paired word from the host
    logic [vram_pkg::WORD_W-1:0] reg_rd_word;      // register value for readback

    // register block to ram
    logic                        ram_we;
    logic [VRAM_ADDR_W-1:0]      ram_addr;
    logic [vram_pkg::WORD_W-1:0] ram_wdata;
    logic [vram_pkg::WORD_W-1:0] ram_rdata;

    bus_interface bus_interface0 (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_data_i     (bus_data_i),
        .reg_data_i     (reg_rd_word),
        .bus_data_o     (bus_data_o),
        .write_strobe_o (write_strobe),
        .read_strobe_o  (read_strobe),
        .reg_num_o      (reg_num),
        .reg_data_o     (bus_wr_word)
    );

    vram_regs #(
        .VRAM_ADDR_W (VRAM_ADDR_W)
    ) vram_regs0 (
        .clk            (clk),
        .reset_i        (reset_i),
        .write_strobe_i (write_strobe),
        .read_strobe_i  (read_strobe),
        .reg_num_i      (reg_num),
        .reg_data_i     (bus_wr_word),
        .ram_rdata_i    (ram_rdata),
        .reg_data_o     (reg_rd_word),
        .ram_we_o       (ram_we),
        .ram_addr_o     (ram_addr),
        .ram_wdata_o    (ram_wdata)
    );

    vram #(
        .ADDR_W (VRAM_ADDR_W)
    ) vram0 (
        .clk     (clk),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

// File: verilog/vram.sv
// ##########################################################################
// video RAM
//   single port word array with synchronous write and registered read
// ##########################################################################

`timescale 1ns/1ps

module vram #(
    parameter int ADDR_W = vram_pkg::VRAM_ADDR_W_DEF
) (
    input  logic                        clk,
    input  logic                        we_i,       // write enable
    input  logic [ADDR_W-1:0]           addr_i,     // shared read/write address
    input  logic [vram_pkg::WORD_W-1:0] wdata_i,
    output logic [vram_pkg::WORD_W-1:0] rdata_o     // word at last cycle's address
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [vram_pkg::WORD_W-1:0] mem [DEPTH];       // contents undefined until written

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];     // old data on a same cycle write
    end

endmodule

// File: verilog/vram_pkg.sv
// ##########################################################################
// video RAM definitions
//   word width of registers and VRAM
//   default VRAM address width
//   prefetch state enum of the register block
// ##########################################################################

package vram_pkg;

    localparam int WORD_W          = 16;    // register and vram word width
    localparam int VRAM_ADDR_W_DEF = 10;    // 1K words unless the top overrides

    // read prefetch sequencing
    typedef enum logic {
        FETCH_IDLE = 1'b0,                  // no read in flight
        FETCH_WAIT = 1'b1                   // ram read data arrives this cycle
    } fetch_state_e;

endpackage

// File: verilog/vram_regs.sv
// ##########################################################################
// VRAM access registers
//   read address, write address and increment registers
//   prefetch word for the data port
//   strobe decode and VRAM read/write sequencing
// ##########################################################################

`timescale 1ns/1ps

module vram_regs #(
    parameter int VRAM_ADDR_W = vram_pkg::VRAM_ADDR_W_DEF
) (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        write_strobe_i, // word written to register
    input  logic                        read_strobe_i,  // word read from register
    input  host_bus_pkg::reg_num_e      reg_num_i,      // register being accessed
    input  logic [vram_pkg::WORD_W-1:0] reg_data_i,     // word from the bus
    input  logic [vram_pkg::WORD_W-1:0] ram_rdata_i,    // ram read data, one cycle late
    output logic [vram_pkg::WORD_W-1:0] reg_data_o,     // word read back to the bus
    output logic                        ram_we_o,
    output logic [VRAM_ADDR_W-1:0]      ram_addr_o,
    output logic [vram_pkg::WORD_W-1:0] ram_wdata_o
);

    logic [VRAM_ADDR_W-1:0]      rd_addr_r;        // next address to prefetch from
    logic [VRAM_ADDR_W-1:0]      wr_addr_r;        // next address to write
    logic [VRAM_ADDR_W-1:0]      rd_addr_next;
    logic [VRAM_ADDR_W-1:0]      incr_step;        // increment cut to address width
    logic [vram_pkg::WORD_W-1:0] incr_r;           // full word kept for readback
    logic [vram_pkg::WORD_W-1:0] prefetch_r;       // word returned by the data port
    logic [vram_pkg::WORD_W-1:0] rd_addr_ext;
    logic [vram_pkg::WORD_W-1:0] wr_addr_ext;
    vram_pkg::fetch_state_e      fetch_state_r;

    // strobe decode
    logic wr_rd_addr_hit;
    logic wr_wr_addr_hit;
    logic wr_data_hit;
    logic wr_incr_hit;
    logic rd_data_hit;
    logic fetch_start;

    assign wr_rd_addr_hit = write_strobe_i && (reg_num_i == host_bus_pkg::REG_RD_ADDR);
    assign wr_wr_addr_hit = write_strobe_i && (reg_num_i == host_bus_pkg::REG_WR_ADDR);
    assign wr_data_hit    = write_strobe_i && (reg_num_i == host_bus_pkg::REG_DATA);
    assign wr_incr_hit    = write_strobe_i && (reg_num_i == host_bus_pkg::REG_INCR);
    assign rd_data_hit    = read_strobe_i && (reg_num_i == host_bus_pkg::REG_DATA);
    assign fetch_start    = wr_rd_addr_hit || rd_data_hit;

    assign incr_step = incr_r[VRAM_ADDR_W-1:0];

    // read address as it will be after this cycle
    always_comb begin
        rd_addr_next = rd_addr_r;
        if (wr_rd_addr_hit) begin
            rd_addr_next = reg_data_i[VRAM_ADDR_W-1:0];
        end else if (rd_data_hit) begin
            rd_addr_next = rd_addr_r + incr_step;   // step past the word just read
        end
    end

    // ram port, writes take the address ahead of a fetch
    assign ram_we_o    = wr_data_hit;
    assign ram_wdata_o = reg_data_i;
    assign ram_addr_o  = wr_data_hit ? wr_addr_r : rd_addr_next;

    // zero extended addresses for readback
    always_comb begin
        rd_addr_ext                    = '0;
        rd_addr_ext[VRAM_ADDR_W-1:0]   = rd_addr_r;
        wr_addr_ext                    = '0;
        wr_addr_ext[VRAM_ADDR_W-1:0]   = wr_addr_r;
    end

    always_comb begin
        case (reg_num_i)
            host_bus_pkg::REG_RD_ADDR: reg_data_o = rd_addr_ext;
            host_bus_pkg::REG_WR_ADDR: reg_data_o = wr_addr_ext;
            host_bus_pkg::REG_DATA:    reg_data_o = prefetch_r;
            host_bus_pkg::REG_INCR:    reg_data_o = incr_r;
            default:                   reg_data_o = '0;  // 4 to F handled by bus side
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_addr_r     <= '0;
            wr_addr_r     <= '0;
            incr_r        <= '0;
            prefetch_r    <= '0;
            fetch_state_r <= vram_pkg::FETCH_IDLE;
        end else begin
            rd_addr_r <= rd_addr_next;
            if (wr_wr_addr_hit) begin
                wr_addr_r <= reg_data_i[VRAM_ADDR_W-1:0];
            end else if (wr_data_hit) begin
                wr_addr_r <= wr_addr_r + incr_step;     // advance after the write
            end
            if (wr_incr_hit) begin
                incr_r <= reg_data_i;
            end
            case (fetch_state_r)
                vram_pkg::FETCH_IDLE: begin
                    if (fetch_start) begin
                        fetch_state_r <= vram_pkg::FETCH_WAIT;  // ram samples address now
                    end
                end
                vram_pkg::FETCH_WAIT: begin
                    prefetch_r    <= ram_rdata_i;                // read word is back
                    fetch_state_r <= fetch_start ? vram_pkg::FETCH_WAIT : vram_pkg::FETCH_IDLE;
                end
                default: fetch_state_r <= vram_pkg::FETCH_IDLE;
            endcase
        end
    end

endmodule
